/* design/cp15LineCounter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cp15_defs.svh"

module cp15LineCounter (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       lineClear,
  input  wire logic       lineStep,
  output cp15Pkg::lineIdx lineIndex,
  output logic            lastLine
);

  import cp15Pkg::*;

  // Walk position, clear wins over step
  always_ff @(posedge clk) begin
    if (reset) begin
      lineIndex <= '0;
    end else if (lineClear) begin
      lineIndex <= '0;
    end else if (lineStep) begin
      lineIndex <= lineIndex + lineIdx'(1);
    end
  end

  // Final line of the cache
  assign lastLine = (lineIndex == lineIdx'(`CP15_CACHE_LINES - 1));

endmodule

`default_nettype wire

/* design/cp15MaintDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module cp15MaintDecode (
  input  wire logic                 writeStrobe,
  input  wire cp15Pkg::regAddr      addr,
  input  wire cp15Pkg::opcode2Field opcode2,
  input  wire cp15Pkg::crmField     crm,
  output logic                      reqFlushI,
  output logic                      reqFlushD,
  output logic                      reqCleanI,
  output logic                      reqCleanD,
  output logic                      reqTlbI,
  output logic                      reqTlbD
);

  logic opValid;
  logic cacheOp;
  logic tlbOp;

  // Only opcode_2 of 0 or 1 selects a maintenance operation
  assign opValid = (opcode2[2:1] == 2'b00);

  assign cacheOp = writeStrobe & opValid & (addr == 4'd7);
  assign tlbOp   = writeStrobe & opValid & (addr == 4'd8);

  // **************************************************
  // R7 cache operations
  // **************************************************

  always_comb begin
    {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b0000;
    if (cacheOp) begin
      case (crm)
        4'd7:    {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b1100;
        4'd5:    {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b1000;
        4'd6:    {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b0100;
        4'd11:   {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b0011;
        4'd10:   {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b0001;
        4'd15:   {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b1111;
        4'd14:   {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b0101;
        default: {reqFlushI, reqFlushD, reqCleanI, reqCleanD} = 4'b0000;
      endcase
    end
  end

  // **************************************************
  // R8 TLB operations
  // **************************************************

  always_comb begin
    {reqTlbI, reqTlbD} = 2'b00;
    if (tlbOp) begin
      case (crm)
        // Both TLBs
        4'd7:    {reqTlbI, reqTlbD} = 2'b11;
        // Instruction TLB
        4'd5:    {reqTlbI, reqTlbD} = 2'b10;
        // Data TLB
        4'd6:    {reqTlbI, reqTlbD} = 2'b01;
        default: {reqTlbI, reqTlbD} = 2'b00;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/cp15MaintSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module cp15MaintSequencer (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       reqFlushI,
  input  wire logic       reqFlushD,
  input  wire logic       reqCleanI,
  input  wire logic       reqCleanD,
  input  wire logic       reqTlbI,
  input  wire logic       reqTlbD,
  input  wire cp15Pkg::lineIdx lineIndex,
  input  wire logic       lastLine,
  output logic            lineClear,
  output logic            lineStep,
  output logic            FlushI,
  output logic            FlushD,
  output logic            CleanI,
  output logic            CleanD,
  output logic            TLBFlushI,
  output logic            TLBFlushD,
  output logic            maintBusy,
  output cp15Pkg::lineIdx cleanLine
);

  import cp15Pkg::*;

  maintState state;
  logic      pendFlushI;
  logic      pendFlushD;
  logic      anyClean;

  assign anyClean = reqCleanI | reqCleanD;

  // **************************************************
  // Counter control
  // **************************************************

  // Counter parks at 0 while idle so a walk starts at line 0
  assign lineClear = (state == stIdle);
  assign lineStep  = (state == stClean);
  assign cleanLine = lineIndex;

  assign maintBusy = (state != stIdle);

  // **************************************************
  // Sequencer FSM
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= stIdle;
      pendFlushI <= 1'b0;
      pendFlushD <= 1'b0;
      FlushI     <= 1'b0;
      FlushD     <= 1'b0;
      CleanI     <= 1'b0;
      CleanD     <= 1'b0;
      TLBFlushI  <= 1'b0;
      TLBFlushD  <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          TLBFlushI <= reqTlbI;
          TLBFlushD <= reqTlbD;
          if (anyClean) begin
            // Flushes wait until the walk is done
            state      <= stClean;
            CleanI     <= reqCleanI;
            CleanD     <= reqCleanD;
            pendFlushI <= reqFlushI;
            pendFlushD <= reqFlushD;
            FlushI     <= 1'b0;
            FlushD     <= 1'b0;
          end else begin
            // Flush-only operations pulse for one cycle
            FlushI <= reqFlushI;
            FlushD <= reqFlushD;
          end
        end
        stClean: begin
          TLBFlushI <= 1'b0;
          TLBFlushD <= 1'b0;
          if (lastLine) begin
            CleanI <= 1'b0;
            CleanD <= 1'b0;
            FlushI <= pendFlushI;
            FlushD <= pendFlushD;
            state  <= (pendFlushI | pendFlushD) ? stFlush : stIdle;
          end
        end
        stFlush: begin
          FlushI     <= 1'b0;
          FlushD     <= 1'b0;
          pendFlushI <= 1'b0;
          pendFlushD <= 1'b0;
          state      <= stIdle;
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/cp15Pkg.sv */
`default_nettype none

`include "cp15_defs.svh"

package cp15Pkg;

  // Register contents and bus values
  typedef logic [31:0] regData;

  // Register number
  typedef logic [3:0] regAddr;

  // Coprocessor operand fields from MCR/MRC
  typedef logic [3:0] crmField;
  typedef logic [2:0] opcode2Field;

  // Cache line index used by the clean walk
  typedef logic [`CP15_LINE_IDX_W-1:0] lineIdx;

  // Maintenance sequencer states
  typedef enum logic [1:0] {
    stIdle,
    stClean,
    stFlush
  } maintState;

endpackage

`default_nettype wire

/* design/cp15RegFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cp15_defs.svh"

module cp15RegFile (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            CPUEn,
  input  wire logic            CPUWriteEn,
  input  wire logic            MMUEn,
  input  wire logic            MMUWriteEn,
  input  wire cp15Pkg::regAddr addr,
  input  wire cp15Pkg::regData CPUWriteData,
  input  wire cp15Pkg::regData MMUWriteData,
  output cp15Pkg::regData      rd,
  output cp15Pkg::regData      control,
  output cp15Pkg::regData      tbase,
  output logic                 writeStrobe,
  output logic                 portConflict
);

  import cp15Pkg::*;

  regData rf [`CP15_NUM_REGS];
  regData wd;
  regData writeMask;
  logic   we;
  logic   re;

  // Writable bits per register, zero means the register ignores writes
  function automatic regData maskFor(input regAddr a);
    regData m;
    case (a)
      4'd1:    m = 32'h0000FFFF;
      4'd2:    m = 32'hFFFFC000;
      4'd3:    m = 32'hFFFFFFFF;
      4'd5:    m = 32'h000001FF;
      4'd6:    m = 32'hFFFFFFFF;
      default: m = '0;
    endcase
    return m;
  endfunction

  function automatic regData resetFor(input regAddr a);
    regData v;
    case (a)
      4'd0:    v = `CP15_ID_RESET;
      4'd1:    v = `CP15_CTRL_RESET;
      default: v = '0;
    endcase
    return v;
  endfunction

  // **************************************************
  // Requester decoding
  // **************************************************

  // Enable without write enable is a read
  assign we = CPUWriteEn | MMUWriteEn;
  assign re = (CPUEn & ~CPUWriteEn) | (MMUEn & ~MMUWriteEn);

  // MMU wins the write port when both write
  assign wd = MMUWriteEn ? MMUWriteData : CPUWriteData;

  // Two writes or two enables in the same cycle
  assign portConflict = (CPUWriteEn & MMUWriteEn) | (CPUEn & MMUEn);

  assign writeStrobe = we;

  // **************************************************
  // Register storage
  // **************************************************

  assign writeMask = maskFor(addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CP15_NUM_REGS; i++) begin
        rf[i] <= resetFor(regAddr'(i));
      end
    end else if (we) begin
      // Only the masked bits take the new value
      rf[addr] <= (rf[addr] & ~writeMask) | (wd & writeMask);
    end
  end

  // Read port returns zero when nobody reads
  assign rd = re ? rf[addr] : '0;

  // Control and translation base are always visible
  assign control = rf[1];
  assign tbase   = rf[2];

endmodule

`default_nettype wire

/* design/cp15Top.sv */
`timescale 1ns/10ps
`default_nettype none

module cp15Top (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 CPUEn,
  input  wire logic                 CPUWriteEn,
  input  wire logic                 MMUEn,
  input  wire logic                 MMUWriteEn,
  input  wire cp15Pkg::regAddr      addr,
  input  wire cp15Pkg::regData      CPUWriteData,
  input  wire cp15Pkg::regData      MMUWriteData,
  input  wire cp15Pkg::opcode2Field opcode2,
  input  wire cp15Pkg::crmField     CRm,
  output cp15Pkg::regData           rd,
  output cp15Pkg::regData           control,
  output cp15Pkg::regData           tbase,
  output logic                      StallCP,
  output logic                      FlushI,
  output logic                      FlushD,
  output logic                      CleanI,
  output logic                      CleanD,
  output logic                      TLBFlushI,
  output logic                      TLBFlushD,
  output cp15Pkg::lineIdx           cleanLine
);

  import cp15Pkg::*;

  logic   writeStrobe;
  logic   portConflict;
  logic   reqFlushI;
  logic   reqFlushD;
  logic   reqCleanI;
  logic   reqCleanD;
  logic   reqTlbI;
  logic   reqTlbD;
  logic   lineClear;
  logic   lineStep;
  logic   lastLine;
  logic   maintBusy;
  lineIdx lineIndex;

  // Port conflicts and running maintenance both hold the requesters
  assign StallCP = portConflict | maintBusy;

  cp15RegFile u_regFile (
    .clk(clk), .reset(reset),
    .CPUEn(CPUEn), .CPUWriteEn(CPUWriteEn),
    .MMUEn(MMUEn), .MMUWriteEn(MMUWriteEn),
    .addr(addr), .CPUWriteData(CPUWriteData), .MMUWriteData(MMUWriteData),
    .rd(rd), .control(control), .tbase(tbase),
    .writeStrobe(writeStrobe), .portConflict(portConflict)
  );

  cp15MaintDecode u_decode (
    .writeStrobe(writeStrobe), .addr(addr), .opcode2(opcode2), .crm(CRm),
    .reqFlushI(reqFlushI), .reqFlushD(reqFlushD),
    .reqCleanI(reqCleanI), .reqCleanD(reqCleanD),
    .reqTlbI(reqTlbI), .reqTlbD(reqTlbD)
  );

  cp15MaintSequencer u_sequencer (
    .clk(clk), .reset(reset),
    .reqFlushI(reqFlushI), .reqFlushD(reqFlushD),
    .reqCleanI(reqCleanI), .reqCleanD(reqCleanD),
    .reqTlbI(reqTlbI), .reqTlbD(reqTlbD),
    .lineIndex(lineIndex), .lastLine(lastLine),
    .lineClear(lineClear), .lineStep(lineStep),
    .FlushI(FlushI), .FlushD(FlushD), .CleanI(CleanI), .CleanD(CleanD),
    .TLBFlushI(TLBFlushI), .TLBFlushD(TLBFlushD),
    .maintBusy(maintBusy), .cleanLine(cleanLine)
  );

  cp15LineCounter u_lineCounter (
    .clk(clk), .reset(reset),
    .lineClear(lineClear), .lineStep(lineStep),
    .lineIndex(lineIndex), .lastLine(lastLine)
  );

endmodule

`default_nettype wire

/* design/cp15_defs.svh */
`ifndef CP15_DEFS_SVH
`define CP15_DEFS_SVH

// Register file geometry
`define CP15_NUM_REGS 16

// Cache lines walked by one clean operation
`define CP15_CACHE_LINES 16

// Width of the cache line index
`define CP15_LINE_IDX_W 4

// Reset value of the read-only ID register (R0)
`define CP15_ID_RESET 32'h41069265

// Reset value of the control register (R1)
`define CP15_CTRL_RESET 32'h00090078

`endif

/* list.f */
+incdir+design
+incdir+verif
design/cp15Pkg.sv
design/cp15RegFile.sv
design/cp15MaintDecode.sv
design/cp15LineCounter.sv
design/cp15MaintSequencer.sv
design/cp15Top.sv
verif/cp15Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the CP15 testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/10ps -f list.f \
  --top-module cp15Tb --Mdir "$BUILD_DIR" -o cp15Sim
if [ $? -ne 0 ]; then
  echo "Verilator compile step returned an error"
  exit 1
fi

"./$BUILD_DIR/cp15Sim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

# Result comes from the log
if grep -q "test failed" "$LOG_FILE"; then
  exit 1
fi
exit 0

/* verif/cp15TbTests.svh */
`ifndef CP15_TB_TESTS_SVH
`define CP15_TB_TESTS_SVH

// **************************************************
// Directed tests
// **************************************************

task automatic testAfterReset();
  startTest("afterReset");
  checkMaint("reset", 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  checkLine("cleanLine", '0, cleanLine);
  checkData("control", model[1], control);
  checkData("tbase", model[2], tbase);
  expectReg(4'd0);
  expectReg(4'd1);
  finishTest();
endtask

task automatic testMaskedWrites();
  regAddr targets [4];
  targets = '{4'd1, 4'd2, 4'd5, 4'd6};
  startTest("maskedWrites");
  foreach (targets[k]) begin
    writeReg(1'b0, targets[k], $urandom, 3'd0, 4'd0);
    // Exposed registers follow one cycle after the write
    checkData("control", model[1], control);
    checkData("tbase", model[2], tbase);
    expectReg(targets[k]);
  end
  // ID register and an unimplemented one keep their value
  writeReg(1'b0, 4'd0, $urandom, 3'd0, 4'd0);
  expectReg(4'd0);
  writeReg(1'b0, 4'd4, $urandom, 3'd0, 4'd0);
  expectReg(4'd4);
  finishTest();
endtask

task automatic testPortSharing();
  regData cpuD;
  regData mmuD;
  startTest("portSharing");
  // A lone MMU write takes the port without a stall
  mmuD         = $urandom;
  addr         = 4'd3;
  MMUEn        = 1'b1;
  MMUWriteEn   = 1'b1;
  MMUWriteData = mmuD;
  model[3]     = (model[3] & ~writableBits[3]) | (mmuD & writableBits[3]);
  #1;
  checkBit("StallCP on MMU write alone", 1'b0, StallCP);
  @(negedge clk);
  setIdle();
  expectReg(4'd3);

  // Both requesters write and the MMU data is stored
  cpuD         = $urandom;
  mmuD         = $urandom;
  addr         = 4'd6;
  CPUEn        = 1'b1;
  CPUWriteEn   = 1'b1;
  CPUWriteData = cpuD;
  MMUEn        = 1'b1;
  MMUWriteEn   = 1'b1;
  MMUWriteData = mmuD;
  model[6]     = (model[6] & ~writableBits[6]) | (mmuD & writableBits[6]);
  #1;
  checkBit("StallCP on two writes", 1'b1, StallCP);
  @(negedge clk);
  setIdle();
  #1;
  checkBit("StallCP once idle", 1'b0, StallCP);
  @(negedge clk);
  expectReg(4'd6);

  // Two reads at once
  addr  = 4'd1;
  CPUEn = 1'b1;
  MMUEn = 1'b1;
  #1;
  checkBit("StallCP on two enables", 1'b1, StallCP);
  checkData("rd on two reads", model[1], rd);
  @(negedge clk);
  setIdle();
  finishTest();
endtask

task automatic pulseCase(input regAddr a, input opcode2Field op2, input crmField crm,
                         input logic fi, input logic fd, input logic ti, input logic td);
  string tag;
  tag = $sformatf("R%0d op2=%0d CRm=%0d", a, op2, crm);
  writeReg(1'b0, a, $urandom, op2, crm);
  checkMaint(tag, fi, fd, 1'b0, 1'b0, ti, td, 1'b0);
  nextCycle();
  checkMaint({tag, " next"}, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
endtask

task automatic testPulses();
  opcode2Field op2;
  startTest("pulses");
  for (int k = 0; k < 2; k++) begin
    op2 = opcode2Field'(k);
    pulseCase(4'd7, op2, 4'd7, 1'b1, 1'b1, 1'b0, 1'b0);
    pulseCase(4'd7, op2, 4'd5, 1'b1, 1'b0, 1'b0, 1'b0);
    pulseCase(4'd7, op2, 4'd6, 1'b0, 1'b1, 1'b0, 1'b0);
    pulseCase(4'd8, op2, 4'd7, 1'b0, 1'b0, 1'b1, 1'b1);
    pulseCase(4'd8, op2, 4'd5, 1'b0, 1'b0, 1'b1, 1'b0);
    pulseCase(4'd8, op2, 4'd6, 1'b0, 1'b0, 1'b0, 1'b1);
  end
  // opcode_2 above 1 selects no operation even for clean encodings
  for (int k = 2; k < 8; k++) begin
    op2 = opcode2Field'(k);
    pulseCase(4'd7, op2, 4'd7, 1'b0, 1'b0, 1'b0, 1'b0);
    pulseCase(4'd7, op2, 4'd15, 1'b0, 1'b0, 1'b0, 1'b0);
    pulseCase(4'd8, op2, 4'd7, 1'b0, 1'b0, 1'b0, 1'b0);
  end
  finishTest();
endtask

// Walk all lines with a second request injected mid-walk
task automatic cleanWalk(input crmField crm, input logic withFlush,
                         input regAddr lateAddr, input crmField lateCrm);
  string tag;
  tag = $sformatf("walk CRm=%0d", crm);
  waitIdle(40);
  writeReg(1'b0, 4'd7, $urandom, 3'd0, crm);
  for (int i = 0; i < `CP15_CACHE_LINES; i++) begin
    checkMaint($sformatf("%s line %0d", tag, i), 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
    checkLine({tag, " cleanLine"}, lineIdx'(i), cleanLine);
    if (i == 5) begin
      writeReg(1'b0, lateAddr, $urandom, 3'd0, lateCrm);
    end else begin
      nextCycle();
    end
  end
  checkMaint({tag, " end"}, withFlush, withFlush, 1'b0, 1'b0, 1'b0, 1'b0, withFlush);
  nextCycle();
  checkMaint({tag, " done"}, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
endtask

task automatic testCleanWalk();
  startTest("cleanWalk");
  cleanWalk(4'd11, 1'b0, 4'd7, 4'd7);
  cleanWalk(4'd15, 1'b1, 4'd8, 4'd7);
  finishTest();
endtask

`endif

/* verif/cp15Tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cp15_defs.svh"

module cp15Tb;

  import cp15Pkg::*;

  localparam int ClkPeriodNs = 4;
  // Directed tests take about 125 cycles, the watchdog allows four times that
  localparam int TestCycles = 125;
  localparam int WatchdogNs = TestCycles * ClkPeriodNs * 4;

  logic        clk;
  logic        reset;
  logic        CPUEn;
  logic        CPUWriteEn;
  logic        MMUEn;
  logic        MMUWriteEn;
  regAddr      addr;
  regData      CPUWriteData;
  regData      MMUWriteData;
  opcode2Field opcode2;
  crmField     CRm;
  regData      rd;
  regData      control;
  regData      tbase;
  logic        StallCP;
  logic        FlushI;
  logic        FlushD;
  logic        CleanI;
  logic        CleanD;
  logic        TLBFlushI;
  logic        TLBFlushD;
  lineIdx      cleanLine;

  // Expected register contents and writable bits
  regData model [`CP15_NUM_REGS];
  regData writableBits [`CP15_NUM_REGS];

  string curTest;
  int    testErrors;
  int    totalErrors;
  int    testsOk;
  int    testsBad;

  cp15Top u_dut (
    .clk(clk), .reset(reset),
    .CPUEn(CPUEn), .CPUWriteEn(CPUWriteEn),
    .MMUEn(MMUEn), .MMUWriteEn(MMUWriteEn),
    .addr(addr), .CPUWriteData(CPUWriteData), .MMUWriteData(MMUWriteData),
    .opcode2(opcode2), .CRm(CRm),
    .rd(rd), .control(control), .tbase(tbase), .StallCP(StallCP),
    .FlushI(FlushI), .FlushD(FlushD), .CleanI(CleanI), .CleanD(CleanD),
    .TLBFlushI(TLBFlushI), .TLBFlushD(TLBFlushD), .cleanLine(cleanLine)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriodNs / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("test failed");
    $finish;
  end

  // **************************************************
  // Compare tasks and bookkeeping
  // **************************************************

  task automatic noteError();
    testErrors++;
    totalErrors++;
  endtask

  task automatic checkData(input string what, input regData expected, input regData actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: %s expected %h, actual %h", curTest, what, expected, actual);
      noteError();
    end
  endtask

  task automatic checkLine(input string what, input lineIdx expected, input lineIdx actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: %s expected %0d, actual %0d", curTest, what, expected, actual);
      noteError();
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: %s expected %b, actual %b", curTest, what, expected, actual);
      noteError();
    end
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrors = 0;
  endtask

  task automatic finishTest();
    if (testErrors == 0) begin
      $display("%s: ok", curTest);
      testsOk++;
    end else begin
      $display("%s: %0d errors", curTest, testErrors);
      testsBad++;
    end
  endtask

  // **************************************************
  // Drive helpers
  // **************************************************

  task automatic nextCycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic setIdle();
    CPUEn        = 1'b0;
    CPUWriteEn   = 1'b0;
    MMUEn        = 1'b0;
    MMUWriteEn   = 1'b0;
    addr         = '0;
    opcode2      = '0;
    CRm          = '0;
    CPUWriteData = '0;
    MMUWriteData = '0;
  endtask

  task automatic initModel();
    for (int i = 0; i < `CP15_NUM_REGS; i++) begin
      model[i]        = '0;
      writableBits[i] = '0;
    end
    model[0]        = 32'h41069265;
    model[1]        = 32'h00090078;
    writableBits[1] = 32'h0000FFFF;
    writableBits[2] = 32'hFFFFC000;
    writableBits[3] = 32'hFFFFFFFF;
    writableBits[5] = 32'h000001FF;
    writableBits[6] = 32'hFFFFFFFF;
  endtask

  // One write cycle from a single requester, returns one cycle later
  task automatic writeReg(input logic fromMmu, input regAddr a, input regData d,
                          input opcode2Field op2, input crmField crm);
    addr    = a;
    opcode2 = op2;
    CRm     = crm;
    if (fromMmu) begin
      MMUEn        = 1'b1;
      MMUWriteEn   = 1'b1;
      MMUWriteData = d;
    end else begin
      CPUEn        = 1'b1;
      CPUWriteEn   = 1'b1;
      CPUWriteData = d;
    end
    model[a] = (model[a] & ~writableBits[a]) | (d & writableBits[a]);
    nextCycle();
    setIdle();
  endtask

  task automatic readReg(input regAddr a, output regData v);
    addr       = a;
    CPUEn      = 1'b1;
    CPUWriteEn = 1'b0;
    #1;
    v = rd;
    @(negedge clk);
    setIdle();
  endtask

  task automatic expectReg(input regAddr a);
    regData value;
    readReg(a, value);
    checkData($sformatf("R%0d", a), model[a], value);
  endtask

  task automatic checkMaint(input string tag, input logic expFlushI, input logic expFlushD,
                            input logic expCleanI, input logic expCleanD,
                            input logic expTlbI, input logic expTlbD, input logic expStall);
    checkBit({tag, " FlushI"}, expFlushI, FlushI);
    checkBit({tag, " FlushD"}, expFlushD, FlushD);
    checkBit({tag, " CleanI"}, expCleanI, CleanI);
    checkBit({tag, " CleanD"}, expCleanD, CleanD);
    checkBit({tag, " TLBFlushI"}, expTlbI, TLBFlushI);
    checkBit({tag, " TLBFlushD"}, expTlbD, TLBFlushD);
    checkBit({tag, " StallCP"}, expStall, StallCP);
  endtask

  task automatic waitIdle(input int maxCycles);
    int n;
    n = 0;
    while (StallCP && n < maxCycles) begin
      nextCycle();
      n++;
    end
    if (StallCP) begin
      $display("Error in %s: sequencer still busy after %0d cycles", curTest, maxCycles);
      noteError();
    end
  endtask

  `include "cp15TbTests.svh"

  initial begin
    void'($urandom(46));
    totalErrors = 0;
    testErrors  = 0;
    testsOk     = 0;
    testsBad    = 0;
    curTest     = "reset";
    initModel();
    reset = 1'b1;
    setIdle();
    repeat (4) @(negedge clk);
    reset = 1'b0;

    testAfterReset();
    testMaskedWrites();
    testPortSharing();
    testPulses();
    testCleanWalk();

    $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
             testsOk, testsBad, totalErrors);
    if (totalErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
